// File: src/riscv_pkg.sv
// RISC-V core-wide definitions
// Word width, data and address word, byte enables and privilege levels
package riscv_pkg;

  localparam int unsigned XLEN = 32;           // Data and address width

  // One data or address word
  typedef logic [XLEN-1:0] word_t;

  // Byte enables of one word access, one bit per byte
  typedef logic [XLEN/8-1:0] be_t;

  // Privilege level
  // Only U and M exist in this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,                        // User mode
    PRIV_LVL_M = 2'b11                         // Machine mode
  } privlvl_e;

endpackage

// File: src/trig_pkg.sv
// Debug trigger definitions
// Trigger type and match kind encodings, tdata1 field positions
// and the reset pattern of a disabled trigger
package trig_pkg;

  // tdata1 type field
  typedef enum logic [3:0] {
    TTYPE_MCONTROL6 = 4'h6,                    // Address match trigger
    TTYPE_DISABLED  = 4'hF                     // Trigger exists but does nothing
  } ttype_e;

  // mcontrol6 match field, WARL (0, 2, 3)
  typedef enum logic [3:0] {
    MATCH_EQ = 4'h0,                           // Address equal
    MATCH_GE = 4'h2,                           // Address greater or equal
    MATCH_LT = 4'h3                            // Address less than
  } match_e;

  ////////////////////////////////////////////////////////////////////////////
  // tdata1 field positions
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned TDATA1_TYPE_HIGH = 31;
  localparam int unsigned TDATA1_TYPE_LOW  = 28;
  localparam int unsigned TDATA1_DMODE     = 27;  // Writable from debug mode only

  localparam int unsigned MC6_HIT0         = 22;  // Set by hardware on a hit
  localparam int unsigned MC6_ACTION_LOW   = 12;  // Action field is 15:12
  localparam int unsigned MC6_MATCH_HIGH   = 10;
  localparam int unsigned MC6_MATCH_LOW    = 7;
  localparam int unsigned MC6_M            = 6;   // Match in machine mode
  localparam int unsigned MC6_U            = 3;   // Match in user mode
  localparam int unsigned MC6_EXECUTE      = 2;   // Match on instruction fetch
  localparam int unsigned MC6_STORE        = 1;   // Match on store
  localparam int unsigned MC6_LOAD         = 0;   // Match on load

  // Disabled type with dmode set, 0xF8000000
  localparam riscv_pkg::word_t TDATA1_RST_VAL = {TTYPE_DISABLED, 1'b1, 27'h0};

  // Only supported action, enter debug mode
  localparam logic [3:0] MC6_ACTION_DEBUG = 4'h1;

endpackage

// File: src/trig_csr_bank.sv
// Debug trigger CSR bank
// Holds tselect plus one tdata1 and tdata2 per trigger, applies the WARL
// write rules, muxes read data by tselect and records hit0 when the
// controller asks for a hit update
`timescale 1ns/1ns

module trig_csr_bank #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  // CSR write port
  input  riscv_pkg::word_t                        csr_wdata_i,
  input  logic                                    tselect_we_i,
  input  logic                                    tdata1_we_i,
  input  logic                                    tdata2_we_i,

  // Hit recording
  input  logic                                    hit_update_i,
  input  logic [NUM_TRIGGERS-1:0]                 match_if_i,   // Fetch matches
  input  logic [NUM_TRIGGERS-1:0]                 match_ex_i,   // Load/store matches

  // CSR read data
  output riscv_pkg::word_t                        tselect_rdata_o,
  output riscv_pkg::word_t                        tdata1_rdata_o,
  output riscv_pkg::word_t                        tdata2_rdata_o,

  // All triggers to the matchers
  output logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata1_all_o,
  output logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata2_all_o
);

  localparam int unsigned XLEN = riscv_pkg::XLEN;

  riscv_pkg::word_t        tselect_q;                 // Index of the visible trigger
  riscv_pkg::word_t        tdata1_q [NUM_TRIGGERS];
  riscv_pkg::word_t        tdata2_q [NUM_TRIGGERS];
  riscv_pkg::word_t        tdata1_wr;                 // Legalized tdata1 write value
  logic [NUM_TRIGGERS-1:0] hit_any;                   // Matched in either stage

  // Match field WARL, unsupported kinds fall back to equal
  function automatic trig_pkg::match_e match_legal(input logic [3:0] raw);
    trig_pkg::match_e kind;
    kind = trig_pkg::match_e'(raw);
    case (kind)
      trig_pkg::MATCH_GE,
      trig_pkg::MATCH_LT: return kind;
      default:            return trig_pkg::MATCH_EQ;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tselect, WARL 0 to NUM_TRIGGERS-1
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i && (csr_wdata_i < NUM_TRIGGERS)) begin
      tselect_q <= csr_wdata_i;                       // Out of range index is dropped
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tdata1 write value
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tdata1_wr = trig_pkg::TDATA1_RST_VAL;             // Any other type disables
    if (trig_pkg::ttype_e'(csr_wdata_i[trig_pkg::TDATA1_TYPE_HIGH:trig_pkg::TDATA1_TYPE_LOW])
        == trig_pkg::TTYPE_MCONTROL6) begin
      tdata1_wr = '0;                                 // Unused fields, hit1 and uncertain
      tdata1_wr[trig_pkg::TDATA1_TYPE_HIGH:trig_pkg::TDATA1_TYPE_LOW] = trig_pkg::TTYPE_MCONTROL6;
      tdata1_wr[trig_pkg::TDATA1_DMODE] = 1'b1;
      tdata1_wr[trig_pkg::MC6_HIT0] = csr_wdata_i[trig_pkg::MC6_HIT0];
      tdata1_wr[trig_pkg::MC6_ACTION_LOW +: 4] = trig_pkg::MC6_ACTION_DEBUG;
      tdata1_wr[trig_pkg::MC6_MATCH_HIGH:trig_pkg::MC6_MATCH_LOW] =
        match_legal(csr_wdata_i[trig_pkg::MC6_MATCH_HIGH:trig_pkg::MC6_MATCH_LOW]);
      tdata1_wr[trig_pkg::MC6_M]       = csr_wdata_i[trig_pkg::MC6_M];
      tdata1_wr[trig_pkg::MC6_U]       = csr_wdata_i[trig_pkg::MC6_U];
      tdata1_wr[trig_pkg::MC6_EXECUTE] = csr_wdata_i[trig_pkg::MC6_EXECUTE];
      tdata1_wr[trig_pkg::MC6_STORE]   = csr_wdata_i[trig_pkg::MC6_STORE];
      tdata1_wr[trig_pkg::MC6_LOAD]    = csr_wdata_i[trig_pkg::MC6_LOAD];
    end
  end

  assign hit_any = match_if_i | match_ex_i;

  ////////////////////////////////////////////////////////////////////////////
  // Per-trigger registers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : g_trig
    logic sel;                                        // Trigger is behind tselect
    logic is_mc6;

    assign sel    = (tselect_q == i);
    assign is_mc6 = trig_pkg::ttype_e'(
                      tdata1_q[i][trig_pkg::TDATA1_TYPE_HIGH:trig_pkg::TDATA1_TYPE_LOW])
                    == trig_pkg::TTYPE_MCONTROL6;

    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        tdata1_q[i] <= trig_pkg::TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end else begin
        // Software writes and hit updates never share a cycle
        if (tdata1_we_i && sel) begin
          tdata1_q[i] <= tdata1_wr;
        end else if (hit_update_i && is_mc6 && hit_any[i]) begin
          tdata1_q[i][trig_pkg::MC6_HIT0] <= 1'b1;    // Sticky until software clears it
        end
        if (tdata2_we_i && sel) begin
          tdata2_q[i] <= csr_wdata_i;                 // Any value is legal
        end
      end
    end

    assign tdata1_all_o[i*XLEN +: XLEN] = tdata1_q[i];
    assign tdata2_all_o[i*XLEN +: XLEN] = tdata2_q[i];
  end

  // Read data of the selected trigger
  always_comb begin
    tdata1_rdata_o = tdata1_q[0];
    tdata2_rdata_o = tdata2_q[0];
    for (int unsigned i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == i) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;

endmodule

// File: src/exec_addr_match.sv
// Instruction address trigger match
// Compares the fetch PC with tdata2 of every trigger, gated by type,
// execute enable, privilege, debug mode and pointer fetches
`timescale 1ns/1ns

module exec_addr_match #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata1_all_i,
  input  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata2_all_i,
  input  riscv_pkg::word_t                        pc_if_i,
  input  logic                                    ptr_in_if_i,   // Fetched word is a pointer
  input  riscv_pkg::privlvl_e                     priv_lvl_if_i,
  input  logic                                    debug_mode_i,
  output logic [NUM_TRIGGERS-1:0]                 match_if_o
);

  localparam int unsigned XLEN = riscv_pkg::XLEN;

  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : g_trig
    riscv_pkg::word_t tdata1;
    riscv_pkg::word_t tdata2;
    logic             addr_hit;                       // Compare result for the match kind
    logic             priv_en;
    logic             is_mc6;

    assign tdata1 = tdata1_all_i[i*XLEN +: XLEN];
    assign tdata2 = tdata2_all_i[i*XLEN +: XLEN];

    // Unsigned compare selected by the match field
    always_comb begin
      case (trig_pkg::match_e'(tdata1[trig_pkg::MC6_MATCH_HIGH:trig_pkg::MC6_MATCH_LOW]))
        trig_pkg::MATCH_EQ: addr_hit = (pc_if_i == tdata2);
        trig_pkg::MATCH_GE: addr_hit = (pc_if_i >= tdata2);
        trig_pkg::MATCH_LT: addr_hit = (pc_if_i <  tdata2);
        default:            addr_hit = 1'b0;      // Never stored
      endcase
    end

    assign priv_en = (tdata1[trig_pkg::MC6_M] && (priv_lvl_if_i == riscv_pkg::PRIV_LVL_M)) ||
                     (tdata1[trig_pkg::MC6_U] && (priv_lvl_if_i == riscv_pkg::PRIV_LVL_U));
    assign is_mc6  = trig_pkg::ttype_e'(tdata1[trig_pkg::TDATA1_TYPE_HIGH:trig_pkg::TDATA1_TYPE_LOW])
                     == trig_pkg::TTYPE_MCONTROL6;

    // No match on table jump pointers or while in debug mode
    assign match_if_o[i] = is_mc6 && tdata1[trig_pkg::MC6_EXECUTE] && priv_en && addr_hit &&
                           !debug_mode_i && !ptr_in_if_i;
  end

endmodule

// File: src/lsu_addr_match.sv
// Load/store address trigger match
// Turns the word address and byte enables into the lowest and highest
// accessed byte, then checks each trigger against tdata2 by match kind,
// gated by access direction, type, privilege and debug mode
`timescale 1ns/1ns

module lsu_addr_match #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata1_all_i,
  input  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata2_all_i,
  input  logic                                    lsu_valid_ex_i,
  input  riscv_pkg::word_t                        lsu_addr_ex_i,
  input  logic                                    lsu_we_ex_i,   // 1 for store
  input  riscv_pkg::be_t                          lsu_be_ex_i,
  input  riscv_pkg::privlvl_e                     priv_lvl_ex_i,
  input  logic                                    debug_mode_i,
  output logic [NUM_TRIGGERS-1:0]                 match_ex_o
);

  localparam int unsigned XLEN = riscv_pkg::XLEN;

  logic [1:0]       low_lsb;                          // Lowest set byte enable
  logic [1:0]       high_lsb;                         // Highest set byte enable
  riscv_pkg::word_t addr_low;
  riscv_pkg::word_t addr_high;

  ////////////////////////////////////////////////////////////////////////////
  // Accessed byte range
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    low_lsb  = 2'b00;
    high_lsb = 2'b00;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) high_lsb = 2'(b);           // Last set bit wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) low_lsb = 2'(b);            // First set bit wins
    end
  end

  assign addr_low  = {lsu_addr_ex_i[XLEN-1:2], low_lsb};
  assign addr_high = {lsu_addr_ex_i[XLEN-1:2], high_lsb};

  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : g_trig
    riscv_pkg::word_t tdata1;
    riscv_pkg::word_t tdata2;
    logic             byte_hit;    // Byte at tdata2[1:0] is accessed
    logic             addr_hit;
    logic             dir_en;      // Load or store enabled for this access
    logic             priv_en;
    logic             is_mc6;

    assign tdata1   = tdata1_all_i[i*XLEN +: XLEN];
    assign tdata2   = tdata2_all_i[i*XLEN +: XLEN];
    assign byte_hit = |(lsu_be_ex_i & (4'b0001 << tdata2[1:0]));

    // Equal needs same word and the named byte, GE/LT look at the range ends
    always_comb begin
      case (trig_pkg::match_e'(tdata1[trig_pkg::MC6_MATCH_HIGH:trig_pkg::MC6_MATCH_LOW]))
        trig_pkg::MATCH_EQ: addr_hit = (lsu_addr_ex_i[XLEN-1:2] == tdata2[XLEN-1:2]) && byte_hit;
        trig_pkg::MATCH_GE: addr_hit = (addr_high >= tdata2);
        trig_pkg::MATCH_LT: addr_hit = (addr_low  <  tdata2);
        default:            addr_hit = 1'b0;
      endcase
    end

    assign dir_en  = (tdata1[trig_pkg::MC6_LOAD]  && !lsu_we_ex_i) ||
                     (tdata1[trig_pkg::MC6_STORE] &&  lsu_we_ex_i);
    assign priv_en = (tdata1[trig_pkg::MC6_M] && (priv_lvl_ex_i == riscv_pkg::PRIV_LVL_M)) ||
                     (tdata1[trig_pkg::MC6_U] && (priv_lvl_ex_i == riscv_pkg::PRIV_LVL_U));
    assign is_mc6  = trig_pkg::ttype_e'(tdata1[trig_pkg::TDATA1_TYPE_HIGH:trig_pkg::TDATA1_TYPE_LOW])
                     == trig_pkg::TTYPE_MCONTROL6;

    assign match_ex_o[i] = lsu_valid_ex_i && dir_en && is_mc6 && priv_en && addr_hit &&
                           !debug_mode_i;             // Triggers are off in debug mode
  end

endmodule

// File: src/dbg_triggers.sv
// Debug trigger unit
// NUM_TRIGGERS address match triggers with their CSRs, matching the fetch
// PC and the load/store address, with hit0 recording on controller request
`timescale 1ns/1ns

module dbg_triggers #(
  parameter int unsigned NUM_TRIGGERS = 2           // 1 to 4
) (
  input  logic                    clk,
  input  logic                    rst_n_i,

  // CSR write port
  input  riscv_pkg::word_t        csr_wdata_i,
  input  logic                    tselect_we_i,
  input  logic                    tdata1_we_i,
  input  logic                    tdata2_we_i,

  // CSR read data
  output riscv_pkg::word_t        tselect_rdata_o,
  output riscv_pkg::word_t        tdata1_rdata_o,
  output riscv_pkg::word_t        tdata2_rdata_o,

  // Fetch stage
  input  riscv_pkg::word_t        pc_if_i,
  input  logic                    ptr_in_if_i,
  input  riscv_pkg::privlvl_e     priv_lvl_if_i,

  // Execute stage, LSU
  input  logic                    lsu_valid_ex_i,
  input  riscv_pkg::word_t        lsu_addr_ex_i,
  input  logic                    lsu_we_ex_i,
  input  riscv_pkg::be_t          lsu_be_ex_i,
  input  riscv_pkg::privlvl_e     priv_lvl_ex_i,

  // Controller
  input  logic                    debug_mode_i,
  input  logic                    hit_update_i,     // Record hit0 this cycle

  // Matches
  output logic [NUM_TRIGGERS-1:0] trigger_match_if_o,
  output logic [NUM_TRIGGERS-1:0] trigger_match_ex_o
);

  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata1_all;  // All tdata1, trigger 0 lowest
  logic [NUM_TRIGGERS*riscv_pkg::XLEN-1:0] tdata2_all;
  logic [NUM_TRIGGERS-1:0]                 match_if;
  logic [NUM_TRIGGERS-1:0]                 match_ex;

  trig_csr_bank #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) u_csr_bank (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .hit_update_i    (hit_update_i),
    .match_if_i      (match_if),
    .match_ex_i      (match_ex),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .tdata1_all_o    (tdata1_all),
    .tdata2_all_o    (tdata2_all)
  );

  exec_addr_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_exec_match (
    .tdata1_all_i  (tdata1_all),
    .tdata2_all_i  (tdata2_all),
    .pc_if_i       (pc_if_i),
    .ptr_in_if_i   (ptr_in_if_i),
    .priv_lvl_if_i (priv_lvl_if_i),
    .debug_mode_i  (debug_mode_i),
    .match_if_o    (match_if)
  );

  lsu_addr_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_lsu_match (
    .tdata1_all_i   (tdata1_all),
    .tdata2_all_i   (tdata2_all),
    .lsu_valid_ex_i (lsu_valid_ex_i),
    .lsu_addr_ex_i  (lsu_addr_ex_i),
    .lsu_we_ex_i    (lsu_we_ex_i),
    .lsu_be_ex_i    (lsu_be_ex_i),
    .priv_lvl_ex_i  (priv_lvl_ex_i),
    .debug_mode_i   (debug_mode_i),
    .match_ex_o     (match_ex)
  );

  // Matches leave the unit and also feed hit recording
  assign trigger_match_if_o = match_if;
  assign trigger_match_ex_o = match_ex;

endmodule

// File: bench/dbg_triggers_asserts.sv
// Debug trigger unit assertions
// tselect range, matches off in debug mode and dmode always set
`timescale 1ns/1ns

module dbg_triggers_asserts #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input logic                    clk,
  input logic                    rst_n_i,
  input riscv_pkg::word_t        tselect_rdata_i,
  input riscv_pkg::word_t        tdata1_rdata_i,
  input logic                    debug_mode_i,
  input logic [NUM_TRIGGERS-1:0] match_if_i,
  input logic [NUM_TRIGGERS-1:0] match_ex_i
);

  int unsigned sel_fails   = 0;                       // Failure counts per assertion
  int unsigned dbg_fails   = 0;
  int unsigned dmode_fails = 0;

  a_tsel_range: assert property (@(posedge clk) disable iff (!rst_n_i)
                                 tselect_rdata_i < NUM_TRIGGERS)
    else begin
      $error("tselect out of range: %0d", tselect_rdata_i);
      sel_fails++;
    end

  // Triggers never fire while the core is halted
  a_dbg_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
                                debug_mode_i |-> (match_if_i == '0 && match_ex_i == '0))
    else begin
      $error("Trigger match while in debug mode");
      dbg_fails++;
    end

  a_dmode_set: assert property (@(posedge clk) disable iff (!rst_n_i)
                                tdata1_rdata_i[trig_pkg::TDATA1_DMODE])
    else begin
      $error("tdata1 read with dmode clear: %h", tdata1_rdata_i);
      dmode_fails++;
    end

endmodule

bind dbg_triggers dbg_triggers_asserts #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_asserts (
  .clk             (clk),
  .rst_n_i         (rst_n_i),
  .tselect_rdata_i (tselect_rdata_o),
  .tdata1_rdata_i  (tdata1_rdata_o),
  .debug_mode_i    (debug_mode_i),
  .match_if_i      (trigger_match_if_o),
  .match_ex_i      (trigger_match_ex_o)
);

// File: bench/tb_dbg_triggers.sv
// Debug trigger unit testbench
// Random CSR writes plus fetch and load/store traffic near the tdata2
// values, checked every cycle against a reference model of the CSRs
`timescale 1ns/1ns

module tb_dbg_triggers;

  localparam int unsigned NT          = 3;            // Triggers in the DUT
  localparam int unsigned CYCLES      = 5000;         // Random cycles
  localparam int unsigned RST_TIMEOUT = 20;

  logic                clk;
  logic                rst_n_i;
  riscv_pkg::word_t    csr_wdata_i;
  logic                tselect_we_i;
  logic                tdata1_we_i;
  logic                tdata2_we_i;
  riscv_pkg::word_t    tselect_rdata_o;
  riscv_pkg::word_t    tdata1_rdata_o;
  riscv_pkg::word_t    tdata2_rdata_o;
  riscv_pkg::word_t    pc_if_i;
  logic                ptr_in_if_i;
  riscv_pkg::privlvl_e priv_lvl_if_i;
  logic                lsu_valid_ex_i;
  riscv_pkg::word_t    lsu_addr_ex_i;
  logic                lsu_we_ex_i;
  riscv_pkg::be_t      lsu_be_ex_i;
  riscv_pkg::privlvl_e priv_lvl_ex_i;
  logic                debug_mode_i;
  logic                hit_update_i;
  logic [NT-1:0]       trigger_match_if_o;
  logic [NT-1:0]       trigger_match_ex_o;

  // Reference model state
  riscv_pkg::word_t m_tsel;
  riscv_pkg::word_t m_t1 [NT];
  riscv_pkg::word_t m_t2 [NT];
  logic [NT-1:0]    exp_if = '0;                      // Expected matches of this cycle
  logic [NT-1:0]    exp_ex = '0;
  int unsigned      errors = 0;
  int unsigned      timeouts = 0;

  dbg_triggers #(.NUM_TRIGGERS(NT)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                            // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Type 6 keeps hit0 M U execute store load and fixes the rest
  function automatic riscv_pkg::word_t legal_tdata1(input riscv_pkg::word_t w);
    riscv_pkg::word_t r;
    if (w[31:28] != 4'h6) return 32'hF800_0000;       // Disabled with dmode set
    r = 32'h6800_1000 | (w & 32'h0040_004F);          // Type 6, dmode, action 1
    if (w[10:7] == 4'h2 || w[10:7] == 4'h3) r[10:7] = w[10:7];
    return r;
  endfunction

  function automatic logic priv_ok(input riscv_pkg::word_t t1, input riscv_pkg::privlvl_e p);
    return (t1[6] && p == riscv_pkg::PRIV_LVL_M) || (t1[3] && p == riscv_pkg::PRIV_LVL_U);
  endfunction

  function automatic logic fetch_hit(input riscv_pkg::word_t t1, input riscv_pkg::word_t t2);
    logic cmp;
    case (t1[10:7])
      4'h2:    cmp = pc_if_i >= t2;
      4'h3:    cmp = pc_if_i < t2;
      default: cmp = pc_if_i == t2;
    endcase
    return t1[31:28] == 4'h6 && t1[2] && priv_ok(t1, priv_lvl_if_i) && cmp &&
           !debug_mode_i && !ptr_in_if_i;
  endfunction

  function automatic logic lsu_hit(input riscv_pkg::word_t t1, input riscv_pkg::word_t t2);
    int   lo;
    int   hi;
    logic cmp;
    lo = 4;
    hi = 0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b] && lo == 4) lo = b;          // Lowest accessed byte
      if (lsu_be_ex_i[b]) hi = b;                     // Highest accessed byte
    end
    case (t1[10:7])
      4'h2:    cmp = {lsu_addr_ex_i[31:2], 2'(hi)} >= t2;
      4'h3:    cmp = {lsu_addr_ex_i[31:2], 2'(lo)} < t2;
      default: cmp = lsu_addr_ex_i[31:2] == t2[31:2] && lsu_be_ex_i[t2[1:0]];
    endcase
    return lsu_valid_ex_i && ((t1[0] && !lsu_we_ex_i) || (t1[1] && lsu_we_ex_i)) &&
           t1[31:28] == 4'h6 && priv_ok(t1, priv_lvl_ex_i) && cmp && !debug_mode_i;
  endfunction

  // Register updates at a rising edge from the inputs held before it
  task automatic model_clock();
    for (int t = 0; t < NT; t++) begin
      if (tdata1_we_i && m_tsel == t) m_t1[t] = legal_tdata1(csr_wdata_i);
      else if (hit_update_i && m_t1[t][31:28] == 4'h6 && (exp_if[t] || exp_ex[t]))
        m_t1[t][22] = 1'b1;                           // hit0
      if (tdata2_we_i && m_tsel == t) m_t2[t] = csr_wdata_i;
    end
    if (tselect_we_i && csr_wdata_i < NT) m_tsel = csr_wdata_i;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic randomize_inputs();
    int unsigned      op;
    int unsigned      tr;
    riscv_pkg::word_t w;
    op = $urandom_range(0, 9);                        // At most one write and never with a hit update
    tr = $urandom_range(0, NT - 1);                   // Trigger whose tdata2 steers traffic
    w  = $urandom;
    if (op == 0) w = $urandom_range(0, 5);
    if (op inside {1, 2}) begin
      case ($urandom_range(0, 3))
        0, 1:    w[31:28] = 4'h6;
        2:       w[31:28] = 4'hF;
        default: ;                                    // Keep a random type
      endcase
      if ($urandom_range(0, 1)) w[10:7] = 4'($urandom_range(2, 3));
    end
    csr_wdata_i    <= w;
    tselect_we_i   <= op == 0;
    tdata1_we_i    <= op inside {1, 2};
    tdata2_we_i    <= op == 3;
    hit_update_i   <= op inside {4, 5};
    pc_if_i        <= m_t2[tr] + 32'($urandom_range(0, 8)) - 32'd4;
    lsu_addr_ex_i  <= m_t2[tr] + 32'($urandom_range(0, 16)) - 32'd8;
    lsu_be_ex_i    <= 4'($urandom_range(1, 15));
    lsu_valid_ex_i <= $urandom_range(0, 3) != 0;
    lsu_we_ex_i    <= $urandom_range(0, 1);
    ptr_in_if_i    <= $urandom_range(0, 7) == 0;
    debug_mode_i   <= $urandom_range(0, 7) == 0;
    priv_lvl_if_i  <= $urandom_range(0, 1) ? riscv_pkg::PRIV_LVL_M : riscv_pkg::PRIV_LVL_U;
    priv_lvl_ex_i  <= $urandom_range(0, 1) ? riscv_pkg::PRIV_LVL_M : riscv_pkg::PRIV_LVL_U;
  endtask

  task automatic check_word(input string name, input riscv_pkg::word_t got,
                            input riscv_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_match(input string name, input logic [NT-1:0] got,
                             input logic [NT-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // One clock of stimulus and checks
  // A negative sel_idx gives random traffic, any other value writes tselect
  task automatic run_cycle(input int sel_idx);
    @(posedge clk);
    model_clock();
    if (sel_idx < 0) begin
      randomize_inputs();
    end else begin
      csr_wdata_i  <= sel_idx;
      tselect_we_i <= 1'b1;
    end
    @(negedge clk);                                   // Outputs settled mid cycle
    for (int t = 0; t < NT; t++) begin
      exp_if[t] = fetch_hit(m_t1[t], m_t2[t]);
      exp_ex[t] = lsu_hit(m_t1[t], m_t2[t]);
    end
    check_word("tselect_rdata_o", tselect_rdata_o, m_tsel);
    check_word("tdata1_rdata_o", tdata1_rdata_o, m_t1[m_tsel]);
    check_word("tdata2_rdata_o", tdata2_rdata_o, m_t2[m_tsel]);
    check_match("trigger_match_if_o", trigger_match_if_o, exp_if);
    check_match("trigger_match_ex_o", trigger_match_ex_o, exp_ex);
  endtask

  task automatic wait_reset(output bit ok);
    int unsigned n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < RST_TIMEOUT) begin
      @(negedge clk);
      ok = rst_n_i && tselect_rdata_o == '0 && tdata1_rdata_o == 32'hF800_0000;
      n++;
    end
    if (!ok) begin
      timeouts++;
      $display("Timeout: DUT read data did not show reset values after reset release");
    end
  endtask

  initial begin
    bit          rst_ok;
    int unsigned a_fails;
    void'($urandom(32'hf436b3db));
    rst_n_i        <= 1'b0;
    csr_wdata_i    <= '0;
    tselect_we_i   <= 1'b0;
    tdata1_we_i    <= 1'b0;
    tdata2_we_i    <= 1'b0;
    pc_if_i        <= '0;
    ptr_in_if_i    <= 1'b0;
    priv_lvl_if_i  <= riscv_pkg::PRIV_LVL_M;
    lsu_valid_ex_i <= 1'b0;
    lsu_addr_ex_i  <= '0;
    lsu_we_ex_i    <= 1'b0;
    lsu_be_ex_i    <= '0;
    priv_lvl_ex_i  <= riscv_pkg::PRIV_LVL_M;
    debug_mode_i   <= 1'b0;
    hit_update_i   <= 1'b0;
    m_tsel = '0;
    for (int t = 0; t < NT; t++) begin
      m_t1[t] = 32'hF800_0000;
      m_t2[t] = '0;
    end
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    wait_reset(rst_ok);
    if (rst_ok) begin
      for (int t = 0; t < NT; t++) run_cycle(t);      // Reset values of every trigger
      for (int c = 0; c < CYCLES; c++) run_cycle(-1);
    end
    @(negedge clk);                                   // Past the last assertion sample
    a_fails = UUT.u_asserts.sel_fails + UUT.u_asserts.dbg_fails + UUT.u_asserts.dmode_fails;
    $display("Errors: %0d value, %0d assertion, %0d timeout", errors, a_fails, timeouts);
    if (errors == 0 && a_fails == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
src/riscv_pkg.sv
src/trig_pkg.sv
src/trig_csr_bank.sv
src/exec_addr_match.sv
src/lsu_addr_match.sv
src/dbg_triggers.sv
bench/dbg_triggers_asserts.sv
bench/tb_dbg_triggers.sv
